/* include/fetch_settings.svh */
// Build-time settings of the instruction fetch front end.
// Include this header wherever a width, the reset address or the
// instruction buffer depth is needed.

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Width of a byte address and of one instruction memory word
`define FE_XLEN 32

// First address fetched after reset, must be word aligned
`define FE_RESET_PC 32'h0000_0100

// Entries of the instruction buffer
// Must be a power of two, at least two
`define FE_BUFFER_DEPTH 4

`endif

/* verilog/fetch_mem_pkg.sv */
// Memory-side types of the fetch unit.
// Holds the address and word types and the request and response
// structs of the instruction memory channel.

`include "fetch_settings.svh"

package fetch_mem_pkg;

    // Byte address of an instruction word
    typedef logic [`FE_XLEN-1:0] addr_t;

    // One word as it comes back from the instruction memory
    typedef logic [`FE_XLEN-1:0] word_t;

    // Request toward the instruction memory
    // A request is taken when fetch is high and the memory does not stall,
    // invalidate tells the memory to drop every request still in flight
    typedef struct packed {
        logic  fetch;
        logic  invalidate;
        addr_t address;
    } fetch_req_t;

    // Response from the instruction memory, in request order
    typedef struct packed {
        logic  valid;
        word_t instruction;
    } fetch_rsp_t;

endpackage : fetch_mem_pkg

/* verilog/fetch_instr_pkg.sv */
// Instruction-side types of the fetch unit.
// Covers the redirect request coming from the back end and the
// instruction handed over at the fetch stage output.

package fetch_instr_pkg;

    import fetch_mem_pkg::*;

    // One instruction parcel, half a memory word
    typedef logic [$bits(word_t)/2-1:0] half_t;

    // Redirect request, each bit is a one-cycle pulse
    // Every source carries its own target so the priority is decided in fetch
    typedef struct packed {
        logic  trap;
        addr_t handler_pc;
        logic  trap_return;
        addr_t return_pc;
        logic  branch_taken;
        addr_t target;
    } redirect_t;

    // Instruction at the fetch stage output
    // A compressed instruction carries its raw halfword, zero extended
    typedef struct packed {
        logic  valid;
        logic  compressed;
        addr_t pc;
        word_t instr;
    } fetched_instr_t;

endpackage : fetch_instr_pkg

/* verilog/fetch_pc_gen.sv */
// Program counter generation for the fetch unit.
// Picks the next fetch address by redirect priority, drives the memory
// request and keeps the address of the last accepted request.

`include "fetch_settings.svh"

module fetch_pc_gen (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  fetch_instr_pkg::redirect_t redirect_i,
    input  logic                       mem_stall_i,
    input  logic                       buf_full_i,
    output fetch_mem_pkg::fetch_req_t  mem_req_o
);

    import fetch_mem_pkg::*;

    // Address of the last request taken by memory
    addr_t pc_q;
    addr_t seq_addr;

    // Redirect target that memory could not take yet because it stalled
    logic  pend_q;
    addr_t pend_addr_q;

    logic  redirect;
    logic  accept;

    assign redirect = redirect_i.trap | redirect_i.trap_return | redirect_i.branch_taken;
    assign seq_addr = pc_q + addr_t'(4);
    assign accept   = mem_req_o.fetch & !mem_stall_i;

    // ========================================================================
    // Next fetch address
    // ========================================================================

    // Trap entry wins over trap return, which wins over a resolved branch.
    // A redirect always fetches, the invalidate it raises empties the buffer
    always_comb begin
        mem_req_o.invalidate = flush_i | redirect;
        mem_req_o.fetch      = 1'b1;

        if (redirect_i.trap) begin
            mem_req_o.address = redirect_i.handler_pc;
        end else if (redirect_i.trap_return) begin
            mem_req_o.address = redirect_i.return_pc;
        end else if (redirect_i.branch_taken) begin
            mem_req_o.address = redirect_i.target;
        end else if (pend_q) begin
            // Keep offering the redirect target while memory stalls
            mem_req_o.address = pend_addr_q;
        end else begin
            // Sequential fetch stays quiet while reset is held
            mem_req_o.address = seq_addr;
            mem_req_o.fetch   = flush_i | (rst_n_i & !buf_full_i);
        end
    end

    // ========================================================================
    // Program counter and pending redirect
    // ========================================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // One word below the reset address so the first increment lands on it
            pc_q   <= addr_t'(`FE_RESET_PC) - addr_t'(4);
            pend_q <= 1'b0;
        end else begin
            if (accept) begin
                pc_q <= mem_req_o.address;
            end

            if (accept) begin
                pend_q <= 1'b0;
            end else if (redirect) begin
                pend_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (redirect & mem_stall_i) begin
            pend_addr_q <= mem_req_o.address;
        end
    end

endmodule : fetch_pc_gen

/* verilog/fetch_buffer.sv */
// In-order instruction buffer between the memory channel and the aligner.
// An entry is reserved with its address when a request is accepted and
// receives its word when the memory answers. The aligner reads the head.

`include "fetch_settings.svh"

module fetch_buffer #(
    parameter int DEPTH = `FE_BUFFER_DEPTH
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      clear_i,
    input  logic                      push_addr_i,
    input  fetch_mem_pkg::addr_t      addr_i,
    input  fetch_mem_pkg::fetch_rsp_t rsp_i,
    input  logic                      pop_i,
    output fetch_mem_pkg::word_t      word_o,
    output fetch_mem_pkg::addr_t      addr_o,
    output logic                      ready_o,
    output logic                      full_o
);

    import fetch_mem_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);
    localparam int PTR_W = IDX_W + 1;

    // One extra bit tells a full queue from an empty one
    typedef logic [PTR_W-1:0] ptr_t;

    addr_t addr_mem [DEPTH];
    word_t word_mem [DEPTH];

    ptr_t res_ptr_q;
    ptr_t fill_ptr_q;
    ptr_t rd_ptr_q;

    logic [IDX_W-1:0] res_idx;
    logic             fill;

    // A request taken together with a clear starts the new queue at entry zero
    assign res_idx = clear_i ? '0 : res_ptr_q[IDX_W-1:0];

    // Responses seen while clearing belong to dropped requests
    assign fill = rsp_i.valid & !clear_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_ptr_q  <= '0;
            fill_ptr_q <= '0;
            rd_ptr_q   <= '0;
        end else if (clear_i) begin
            res_ptr_q  <= push_addr_i ? ptr_t'(1) : ptr_t'(0);
            fill_ptr_q <= '0;
            rd_ptr_q   <= '0;
        end else begin
            if (push_addr_i) begin
                res_ptr_q <= res_ptr_q + ptr_t'(1);
            end
            if (fill) begin
                fill_ptr_q <= fill_ptr_q + ptr_t'(1);
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + ptr_t'(1);
            end
        end
    end

    // The oldest unfilled entry takes the response
    always_ff @(posedge clk_i) begin
        if (push_addr_i) begin
            addr_mem[res_idx] <= addr_i;
        end
        if (fill) begin
            word_mem[fill_ptr_q[IDX_W-1:0]] <= rsp_i.instruction;
        end
    end

    assign word_o  = word_mem[rd_ptr_q[IDX_W-1:0]];
    assign addr_o  = addr_mem[rd_ptr_q[IDX_W-1:0]];
    assign ready_o = fill_ptr_q != rd_ptr_q;

    // Full counts reservations, so every request in flight keeps a slot
    assign full_o = (res_ptr_q - rd_ptr_q) == ptr_t'(DEPTH);

endmodule : fetch_buffer

/* verilog/instr_aligner.sv */
// Instruction realignment and fetch stage register.
// Cuts the buffered memory words into 16-bit compressed and 32-bit
// instructions, fuses those that cross a word boundary and registers
// one instruction per cycle toward the back end.

module instr_aligner (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            clear_i,
    input  logic                            stall_i,
    input  fetch_mem_pkg::word_t            word_i,
    input  fetch_mem_pkg::addr_t            addr_i,
    input  logic                            ready_i,
    output logic                            pop_o,
    output fetch_instr_pkg::fetched_instr_t instr_o
);

    import fetch_mem_pkg::*;
    import fetch_instr_pkg::*;

    half_t lower_half;
    half_t upper_half;
    logic  lower_full;
    logic  upper_full;

    // Lower half of a 32-bit instruction that started in the last word
    half_t upper_q;
    logic  cross_q;

    // The head word was kept to hand out its compressed upper half
    logic  sel_upper_q;

    logic  read;
    logic  hold;
    logic  next_cross;
    logic  next_sel_upper;

    logic  cur_compressed;
    addr_t cur_pc;
    word_t cur_instr;

    logic  valid_q;
    logic  compressed_q;
    addr_t pc_q;
    word_t instr_q;

    assign {upper_half, lower_half} = word_i;

    // Both low bits set mark the first parcel of a 32-bit instruction
    assign lower_full = lower_half[1:0] == 2'b11;
    assign upper_full = upper_half[1:0] == 2'b11;

    assign read  = ready_i & !stall_i;
    assign pop_o = read & !hold;

    // ========================================================================
    // Parcel selection
    // ========================================================================

    always_comb begin
        hold           = 1'b0;
        next_cross     = 1'b0;
        next_sel_upper = 1'b0;

        if (sel_upper_q) begin
            cur_compressed = 1'b1;
            cur_pc         = addr_i + addr_t'(2);
            cur_instr      = word_t'(upper_half);
        end else if (cross_q) begin
            // Saved upper half goes low, this word's lower half goes high
            cur_compressed = 1'b0;
            cur_pc         = addr_i - addr_t'(2);
            cur_instr      = {lower_half, upper_q};
            next_cross     = upper_full;
            next_sel_upper = !upper_full;
            hold           = !upper_full;
        end else if (lower_full) begin
            cur_compressed = 1'b0;
            cur_pc         = addr_i;
            cur_instr      = word_i;
        end else begin
            cur_compressed = 1'b1;
            cur_pc         = addr_i;
            cur_instr      = word_t'(lower_half);
            // A compressed upper half needs this word for one more cycle
            next_cross     = upper_full;
            next_sel_upper = !upper_full;
            hold           = !upper_full;
        end
    end

    // ========================================================================
    // Alignment state and fetch stage register
    // ========================================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cross_q     <= 1'b0;
            sel_upper_q <= 1'b0;
            valid_q     <= 1'b0;
        end else if (clear_i) begin
            cross_q     <= 1'b0;
            sel_upper_q <= 1'b0;
            valid_q     <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= ready_i;

            if (ready_i) begin
                cross_q     <= next_cross;
                sel_upper_q <= next_sel_upper;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (read) begin
            upper_q      <= upper_half;
            compressed_q <= cur_compressed;
            pc_q         <= cur_pc;
            instr_q      <= cur_instr;
        end
    end

    always_comb begin
        instr_o.valid      = valid_q;
        instr_o.compressed = compressed_q;
        instr_o.pc         = pc_q;
        instr_o.instr      = instr_q;
    end

endmodule : instr_aligner

/* verilog/front_end_fetch.sv */
// Top level of the instruction fetch front end.
// PC generation issues requests and reserves buffer entries, the buffer
// collects the memory words and the aligner turns them into instructions.

module front_end_fetch (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            flush_i,
    input  fetch_instr_pkg::redirect_t      redirect_i,
    input  fetch_mem_pkg::fetch_rsp_t       mem_rsp_i,
    input  logic                            mem_stall_i,
    input  logic                            stall_i,
    output fetch_mem_pkg::fetch_req_t       mem_req_o,
    output fetch_instr_pkg::fetched_instr_t instr_o
);

    import fetch_mem_pkg::*;

    logic  push_addr;
    logic  buf_full;
    logic  buf_ready;
    logic  pop;
    word_t buf_word;
    addr_t buf_addr;

    // Memory takes a request on every edge with fetch high and no stall
    assign push_addr = mem_req_o.fetch & !mem_stall_i;

    fetch_pc_gen u_pc_gen (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .flush_i     ( flush_i     ),
        .redirect_i  ( redirect_i  ),
        .mem_stall_i ( mem_stall_i ),
        .buf_full_i  ( buf_full    ),
        .mem_req_o   ( mem_req_o   )
    );

    fetch_buffer u_buffer (
        .clk_i       ( clk_i                ),
        .rst_n_i     ( rst_n_i              ),
        .clear_i     ( mem_req_o.invalidate ),
        .push_addr_i ( push_addr            ),
        .addr_i      ( mem_req_o.address    ),
        .rsp_i       ( mem_rsp_i            ),
        .pop_i       ( pop                  ),
        .word_o      ( buf_word             ),
        .addr_o      ( buf_addr             ),
        .ready_o     ( buf_ready            ),
        .full_o      ( buf_full             )
    );

    instr_aligner u_aligner (
        .clk_i   ( clk_i                ),
        .rst_n_i ( rst_n_i              ),
        .clear_i ( mem_req_o.invalidate ),
        .stall_i ( stall_i              ),
        .word_i  ( buf_word             ),
        .addr_i  ( buf_addr             ),
        .ready_i ( buf_ready            ),
        .pop_o   ( pop                  ),
        .instr_o ( instr_o              )
    );

endmodule : front_end_fetch

/* test/tb_clock_gen.sv */
// Clock and reset source for the fetch front end testbench.
// Makes a 100 ns clock and holds reset low for the first two rising edges.

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        // Release on a falling edge like every other input
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

    always #50 clk_o = ~clk_o;

endmodule : tb_clock_gen

/* test/front_end_fetch_props.sv */
// Concurrent checks on the fetch front end, attached to the top level by bind.
// Covers the output during reset, the output hold under a back-end stall
// and a steady request while the memory stalls.

module front_end_fetch_props (
    input logic                            clk_i,
    input logic                            rst_n_i,
    input logic                            stall_i,
    input logic                            mem_stall_i,
    input fetch_mem_pkg::fetch_req_t       mem_req_i,
    input fetch_instr_pkg::fetched_instr_t instr_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Reset empties the fetch stage register
    reset_clears_output: assert property (
        @(posedge clk_i) !rst_n_i |=> !instr_i.valid
    ) else $error("Fetch output was valid right after a reset cycle");

    // A redirect clears the output even under a stall, so it is left out
    stall_holds_output: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        stall_i && !mem_req_i.invalidate |=> $stable(instr_i)
    ) else $error("Fetch output changed while the back end stalled");

    stalled_fetch_holds_address: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mem_req_i.fetch && mem_stall_i && !mem_req_i.invalidate
        |=> mem_req_i.invalidate || (mem_req_i.fetch && $stable(mem_req_i.address))
    ) else $error("Fetch request dropped or moved while memory stalled");

endmodule : front_end_fetch_props

/* test/tb_front_end_fetch.sv */
// Testbench of the instruction fetch front end.
// Loads a memory image, redirect triggers and the expected instruction stream
// from the test data file, answers fetches with random latency and checks
// every instruction the back end takes.

module tb_front_end_fetch;

    timeunit 1ns;
    timeprecision 1ps;

    import fetch_mem_pkg::*;
    import fetch_instr_pkg::*;

    logic           clk;
    logic           rst_n;
    logic           flush;
    redirect_t      redirect;
    fetch_rsp_t     mem_rsp;
    logic           mem_stall;
    logic           stall;
    fetch_req_t     mem_req;
    fetched_instr_t instr;

    word_t          mem [256];
    fetched_instr_t exp_q [$];
    logic [1:0]     trig_kind [$];
    addr_t          trig_pc [$];
    addr_t          trig_target [$];
    addr_t          req_addr [$];
    int             req_due [$];
    int             exp_idx;
    int             cyc;
    int             last_due;
    int             limit;
    int             mismatches;
    int             other_errors;

    tb_clock_gen u_clk (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    front_end_fetch u_dut (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .flush_i     ( flush     ),
        .redirect_i  ( redirect  ),
        .mem_rsp_i   ( mem_rsp   ),
        .mem_stall_i ( mem_stall ),
        .stall_i     ( stall     ),
        .mem_req_o   ( mem_req   ),
        .instr_o     ( instr     )
    );

    bind front_end_fetch front_end_fetch_props u_props (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .stall_i     ( stall_i     ),
        .mem_stall_i ( mem_stall_i ),
        .mem_req_i   ( mem_req_o   ),
        .instr_i     ( instr_o     )
    );

    // Words outside the image look like 32-bit instructions unique to their address
    function automatic word_t fill_word(addr_t a);
        return {a[31:2], 2'b11} ^ 32'hA5A5_0000;
    endfunction

    function automatic word_t read_word(addr_t a);
        return (a < addr_t'(1024)) ? mem[a[9:2]] : fill_word(a);
    endfunction

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    // Kind 3 raises a branch to a decoy target in the same cycle as the trap
    function automatic redirect_t find_redirect(addr_t pc);
        redirect_t rd;
        rd = '0;
        foreach (trig_pc[i]) begin
            if (trig_pc[i] == pc) begin
                case (trig_kind[i])
                    2'd1: begin
                        rd.branch_taken = 1'b1;
                        rd.target       = trig_target[i];
                    end
                    2'd2: begin
                        rd.trap_return = 1'b1;
                        rd.return_pc   = trig_target[i];
                    end
                    default: begin
                        rd.trap         = 1'b1;
                        rd.handler_pc   = trig_target[i];
                        rd.branch_taken = 1'b1;
                        rd.target       = trig_target[i] + addr_t'('h40);
                    end
                endcase
            end
        end
        return rd;
    endfunction

    task automatic load_testdata();
        int             fd;
        string          line;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    c;
        fetched_instr_t e;
        fd = $fopen("test/fetch_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 3 || line[0] == "#") begin
                continue;
            end
            c = '0;
            void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, b, c));
            case (line[0])
                "M": mem[a[7:0]] = b;
                "T": begin
                    trig_kind.push_back(a[1:0]);
                    trig_pc.push_back(b);
                    trig_target.push_back(c);
                end
                "E": begin
                    e            = '0;
                    e.valid      = 1'b1;
                    e.pc         = a;
                    e.instr      = b;
                    e.compressed = c[0];
                    exp_q.push_back(e);
                end
                default: ;
            endcase
        end
        $fclose(fd);
        if (exp_q.size() == 0) begin
            $display("The test data holds no expected instructions");
            other_errors++;
        end
    endtask

    // ========================================================================
    // One falling edge: memory answer, stalls, output check and redirect
    // ========================================================================

    task automatic run_cycle();
        fetched_instr_t exp;
        redirect_t      rd;
        int             due;
        rd = '0;
        cyc++;
        stall     = ($urandom % 4) == 0;
        mem_stall = ($urandom % 4) == 0;

        // The oldest request answers once its latency has run out
        mem_rsp = '0;
        if (req_due.size() > 0 && req_due[0] <= cyc) begin
            mem_rsp.valid       = 1'b1;
            mem_rsp.instruction = read_word(req_addr.pop_front());
            void'(req_due.pop_front());
        end

        // The back end takes the output at the next rising edge
        if (instr.valid && !stall) begin
            exp = exp_q[exp_idx];
            compare_value($sformatf("pc of #%0d", exp_idx), exp.pc, instr.pc);
            compare_value($sformatf("instr of #%0d", exp_idx), exp.instr, instr.instr);
            compare_value($sformatf("compressed of #%0d", exp_idx),
                          32'(exp.compressed), 32'(instr.compressed));
            exp_idx++;
            rd = find_redirect(instr.pc);
        end
        redirect = rd;

        #1;
        if (mem_req.invalidate) begin
            req_addr.delete();
            req_due.delete();
            last_due = cyc;
        end
        if (mem_req.fetch && !mem_stall) begin
            due = cyc + 1 + int'($urandom % 3);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            req_addr.push_back(mem_req.address);
            req_due.push_back(due);
            last_due = due;
        end
    endtask

    initial begin
        int i;
        void'($urandom(9090));
        flush        = 1'b0;
        redirect     = '0;
        mem_rsp      = '0;
        mem_stall    = 1'b0;
        stall        = 1'b0;
        exp_idx      = 0;
        cyc          = 0;
        last_due     = 0;
        mismatches   = 0;
        other_errors = 0;
        for (i = 0; i < 256; i++) begin
            mem[i] = fill_word(addr_t'(i * 4));
        end
        load_testdata();
        limit = 40 * exp_q.size() + 200;

        @(posedge rst_n);
        while (exp_idx < exp_q.size() && cyc < limit) begin
            run_cycle();
            @(negedge clk);
        end

        if (exp_idx < exp_q.size()) begin
            $display("Timeout after %0d cycles, %0d expected instructions never came out",
                     cyc, exp_q.size() - exp_idx);
            other_errors++;
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_front_end_fetch

/* test/fetch_testdata.txt */
# M word_address word | T kind trigger_pc target (1 branch, 2 trap return, 3 trap and branch)
# E pc instruction compressed, the expected stream in order
M 040 00100093
M 041 00200113
M 042 00300193
M 043 45854505
M 044 00930505
M 045 46010050
M 046 02400063
M 050 00a00513
M 051 00000073
M 060 00014501
M 061 00100073
M 080 34202573
M 081 30200073
T 1 00000118 00000140
T 3 00000144 00000200
T 2 00000204 00000180
E 00000100 00100093 0
E 00000104 00200113 0
E 00000108 00300193 0
E 0000010c 00004505 1
E 0000010e 00004585 1
E 00000110 00000505 1
E 00000112 00500093 0
E 00000116 00004601 1
E 00000118 02400063 0
E 00000140 00a00513 0
E 00000144 00000073 0
E 00000200 34202573 0
E 00000204 30200073 0
E 00000180 00004501 1
E 00000182 00000001 1
E 00000184 00100073 0

/* sources.f */
+incdir+include
verilog/fetch_mem_pkg.sv
verilog/fetch_instr_pkg.sv
verilog/fetch_pc_gen.sv
verilog/fetch_buffer.sv
verilog/instr_aligner.sv
verilog/front_end_fetch.sv
test/tb_clock_gen.sv
test/front_end_fetch_props.sv
test/tb_front_end_fetch.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_front_end_fetch
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
